// File: rtl/audio_pkg.sv
// Audio path shared types: sample formats, stage payload and filter shifts
package audio_pkg;

	// Output sample width, signed
	localparam int SMP_W = 16;

	// Paula DAC output, 14 bits of volume product plus sign
	localparam int DAC_W = 15;

	// PWM-volume variant, only the low 9 bits are meaningful
	localparam int PWM_W = 9;

	// Filter coefficients as right shifts, bigger shift means lower corner
	localparam int LPF_A_SHIFT = 2; // Roughly the 4.4 kHz stage
	localparam int LPF_B_SHIFT = 3; // LED filter, steeper

	typedef logic signed [SMP_W-1:0] sample_t;

	typedef struct packed {
		sample_t left;
		sample_t right;
	} stereo_t;

	// Payload handed from stage to stage along with its strobe
	typedef struct packed {
		stereo_t smp;
		logic    bypass_a; // Skip first low-pass (A1200 mode)
		logic    bypass_b; // Skip second low-pass (LED filter off)
	} audio_beat_t;

endpackage

// File: rtl/paula_sample_format.sv
// Paula sample format stage: picks DAC or PWM samples, widens them, latches filter controls
`timescale 1ns/1ps

module paula_sample_format
	import audio_pkg::*;
(
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              sample_ce,
	input  logic [DAC_W-1:0]  dac_l,
	input  logic [DAC_W-1:0]  dac_r,
	input  logic [PWM_W-1:0]  pwm_l,
	input  logic [PWM_W-1:0]  pwm_r,
	input  logic              pwm_sel,
	input  logic              aud_1200,
	input  logic              flt_manual,
	input  logic              flt_force,
	input  logic              pwr_led,
	output logic              out_strobe,
	output audio_beat_t       out_beat
);

	sample_t dac_wide_l;
	sample_t dac_wide_r;
	sample_t pwm_wide_l;
	sample_t pwm_wide_r;
	logic    flt_en;

	// Left aligned into the 16-bit word
	assign dac_wide_l = {dac_l, {(SMP_W - DAC_W){1'b0}}};
	assign dac_wide_r = {dac_r, {(SMP_W - DAC_W){1'b0}}};
	assign pwm_wide_l = {pwm_l, {(SMP_W - PWM_W){1'b0}}};
	assign pwm_wide_r = {pwm_r, {(SMP_W - PWM_W){1'b0}}};

	// LED filter follows the power LED unless forced from the menu
	assign flt_en = flt_manual ? flt_force : pwr_led;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			out_strobe <= 1'b0;
			out_beat   <= '0;
		end else begin
			out_strobe <= sample_ce;
			if (sample_ce) begin
				out_beat.smp.left  <= pwm_sel ? pwm_wide_l : dac_wide_l;
				out_beat.smp.right <= pwm_sel ? pwm_wide_r : dac_wide_r;
				out_beat.bypass_a  <= aud_1200;
				out_beat.bypass_b  <= ~flt_en; // Controls travel with this sample
			end
		end
	end

endmodule

// File: rtl/audio_lowpass.sv
// First-order low-pass stage on a stereo beat, coefficient given as a right shift
`timescale 1ns/1ps

module audio_lowpass
	import audio_pkg::*;
#(
	parameter int SHIFT = LPF_A_SHIFT
)
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        in_strobe,
	input  audio_beat_t in_beat,
	input  logic        sel_bypass,
	output logic        out_strobe,
	output audio_beat_t out_beat
);

	sample_t state_l;
	sample_t state_r;
	sample_t next_l;
	sample_t next_r;

	// y += (x - y) >>> SHIFT, difference kept in 17 bits so it cannot wrap
	function automatic sample_t lpf_step(input sample_t x, input sample_t st);
		logic signed [SMP_W:0] diff;
		logic signed [SMP_W:0] step;
		diff = {x[SMP_W-1], x} - {st[SMP_W-1], st};
		step = diff >>> SHIFT;
		// Step never exceeds the difference, so the sum stays in range
		lpf_step = st + step[SMP_W-1:0];
	endfunction

	assign next_l = lpf_step(in_beat.smp.left, state_l);
	assign next_r = lpf_step(in_beat.smp.right, state_r);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			out_strobe <= 1'b0;
			state_l    <= '0;
			state_r    <= '0;
			out_beat   <= '0;
		end else begin
			out_strobe <= in_strobe;
			if (in_strobe) begin
				// Filter keeps tracking the input while bypassed
				state_l <= next_l;
				state_r <= next_r;

				if (sel_bypass) begin
					out_beat.smp <= in_beat.smp;
				end else begin
					out_beat.smp.left  <= next_l;
					out_beat.smp.right <= next_r;
				end
				out_beat.bypass_a <= in_beat.bypass_a; // Flags ride along
				out_beat.bypass_b <= in_beat.bypass_b;
			end
		end
	end

endmodule

// File: rtl/audio_mixer.sv
// Output mixer: adds the external synth sample with mute and saturates to 16 bits
`timescale 1ns/1ps

module audio_mixer
	import audio_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        in_strobe,
	input  audio_beat_t in_beat,
	input  sample_t     ext_l,
	input  sample_t     ext_r,
	input  logic        ext_mute,
	output logic        out_strobe,
	output stereo_t     out_smp
);

	sample_t ext_eff_l;
	sample_t ext_eff_r;
	sample_t mix_l;
	sample_t mix_r;

	// 17-bit add, then clamp when the two top bits disagree
	function automatic sample_t mix_clamp(input sample_t a, input sample_t b);
		logic signed [SMP_W:0] sum;
		sum = {a[SMP_W-1], a} + {b[SMP_W-1], b};
		if (sum[SMP_W] ^ sum[SMP_W-1])
			mix_clamp = {sum[SMP_W], {(SMP_W-1){sum[SMP_W-1]}}}; // 7FFF or 8000
		else
			mix_clamp = sum[SMP_W-1:0];
	endfunction

	// Muted synth contributes nothing
	assign ext_eff_l = ext_mute ? '0 : ext_l;
	assign ext_eff_r = ext_mute ? '0 : ext_r;

	assign mix_l = mix_clamp(in_beat.smp.left, ext_eff_l);
	assign mix_r = mix_clamp(in_beat.smp.right, ext_eff_r);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			out_strobe <= 1'b0;
			out_smp    <= '0;
		end else begin
			out_strobe <= in_strobe;
			if (in_strobe) begin
				out_smp.left  <= mix_l;
				out_smp.right <= mix_r;
			end
		end
	end

endmodule

// File: rtl/paula_audio_top.sv
// Paula audio path top: format, two low-pass stages and synth mixer in a 4-cycle pipeline
`timescale 1ns/1ps

module paula_audio_top
	import audio_pkg::*;
(
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              sample_ce,
	input  logic [DAC_W-1:0]  dac_l,
	input  logic [DAC_W-1:0]  dac_r,
	input  logic [PWM_W-1:0]  pwm_l,
	input  logic [PWM_W-1:0]  pwm_r,
	input  logic              pwm_sel,
	input  logic              aud_1200,
	input  logic              flt_manual,
	input  logic              flt_force,
	input  logic              pwr_led,
	input  sample_t           ext_l,
	input  sample_t           ext_r,
	input  logic              ext_mute,
	output logic              audio_strobe,
	output sample_t           audio_l,
	output sample_t           audio_r
);

	logic        fmt_strobe;
	audio_beat_t fmt_beat;
	logic        lpf_a_strobe;
	audio_beat_t lpf_a_beat;
	logic        lpf_b_strobe;
	audio_beat_t lpf_b_beat;
	stereo_t     mix_smp;

	paula_sample_format paula_sample_format_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.sample_ce  (sample_ce),
		.dac_l      (dac_l),
		.dac_r      (dac_r),
		.pwm_l      (pwm_l),
		.pwm_r      (pwm_r),
		.pwm_sel    (pwm_sel),
		.aud_1200   (aud_1200),
		.flt_manual (flt_manual),
		.flt_force  (flt_force),
		.pwr_led    (pwr_led),
		.out_strobe (fmt_strobe),
		.out_beat   (fmt_beat)
	);

	// 4.4 kHz stage, skipped in A1200 mode
	audio_lowpass #(.SHIFT(LPF_A_SHIFT)) lpf_a (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.in_strobe  (fmt_strobe),
		.in_beat    (fmt_beat),
		.sel_bypass (fmt_beat.bypass_a),
		.out_strobe (lpf_a_strobe),
		.out_beat   (lpf_a_beat)
	);

	// LED filter
	audio_lowpass #(.SHIFT(LPF_B_SHIFT)) lpf_b (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.in_strobe  (lpf_a_strobe),
		.in_beat    (lpf_a_beat),
		.sel_bypass (lpf_a_beat.bypass_b),
		.out_strobe (lpf_b_strobe),
		.out_beat   (lpf_b_beat)
	);

	audio_mixer audio_mixer_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.in_strobe  (lpf_b_strobe),
		.in_beat    (lpf_b_beat),
		.ext_l      (ext_l),
		.ext_r      (ext_r),
		.ext_mute   (ext_mute),
		.out_strobe (audio_strobe),
		.out_smp    (mix_smp)
	);

	assign audio_l = mix_smp.left;
	assign audio_r = mix_smp.right;

endmodule

// File: sim/tb_paula_audio.sv
// Paula audio path testbench checking LFSR stimulus against a behavioral model of the pipeline
`timescale 1ns/1ps

module tb_paula_audio
	import audio_pkg::*;
();

	localparam int PHASES            = 6;
	localparam int SAMPLES_PER_PHASE = 400;
	localparam int TIMEOUT_CYCLES    = PHASES * SAMPLES_PER_PHASE * 4 + 200;
	localparam int IDLE_CYCLES       = 10;
	localparam int DRAIN_CYCLES      = 8;

	logic             clk_sys;
	logic             reset;
	logic             sample_ce;
	logic [DAC_W-1:0] dac_l;
	logic [DAC_W-1:0] dac_r;
	logic [PWM_W-1:0] pwm_l;
	logic [PWM_W-1:0] pwm_r;
	logic             pwm_sel;
	logic             aud_1200;
	logic             flt_manual;
	logic             flt_force;
	logic             pwr_led;
	sample_t          ext_l;
	sample_t          ext_r;
	logic             ext_mute;
	logic             audio_strobe;
	sample_t          audio_l;
	sample_t          audio_r;

	logic [31:0] lfsr;
	int          errors;
	int          checks;
	int          cycle_count = 0;
	int          drive_cyc;
	int          sent;
	int          clamp_pos;
	int          clamp_neg;
	logic        idle_check;
	logic        took;

	// Model filter state per channel
	int st_a_l;
	int st_a_r;
	int st_b_l;
	int st_b_r;

	int pend_l[$]; // Filtered samples waiting for the mixer
	int pend_r[$];
	int pend_due[$];
	int exp_l[$];
	int exp_r[$];
	int exp_due[$]; // Cycle in which audio_strobe must be high

	paula_audio_top paula_audio_top_inst (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.sample_ce    (sample_ce),
		.dac_l        (dac_l),
		.dac_r        (dac_r),
		.pwm_l        (pwm_l),
		.pwm_r        (pwm_r),
		.pwm_sel      (pwm_sel),
		.aud_1200     (aud_1200),
		.flt_manual   (flt_manual),
		.flt_force    (flt_force),
		.pwr_led      (pwr_led),
		.ext_l        (ext_l),
		.ext_r        (ext_r),
		.ext_mute     (ext_mute),
		.audio_strobe (audio_strobe),
		.audio_l      (audio_l),
		.audio_r      (audio_r)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw(input int nbits, output logic [31:0] val);
		int i;
		val = '0;
		for (i = 0; i < nbits; i++) begin
			lfsr = lfsr_next(lfsr);
			val  = {val[30:0], lfsr[0]};
		end
	endtask

	function automatic int to_s16(input logic [15:0] v);
		to_s16 = {{16{v[15]}}, v};
	endfunction

	// One step of y += (x - y) / 2^sh rounded toward minus infinity
	function automatic int lp_step(input int x, input int st, input int sh);
		int diff;
		diff    = x - st;
		lp_step = st + (diff >>> sh);
	endfunction

	task automatic check_value(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("Fail %s expected %h actual %h at %0t", name, expected, actual, $time);
		end
	endtask

	task automatic mix_sample(input int p, input int e, output int res);
		int sum;
		sum = p + e;
		if (sum > 32767) begin
			res = 32767;
			clamp_pos++;
		end else if (sum < -32768) begin
			res = -32768;
			clamp_neg++;
		end else begin
			res = sum;
		end
	endtask

	// Drive and model one clock and check outputs at the falling edge
	task drive_cycle(input int phase, input logic allow_ce, output logic ce_out);
		logic [31:0]      r;
		logic             ce_v;
		logic [DAC_W-1:0] dac_l_v;
		logic [DAC_W-1:0] dac_r_v;
		logic [PWM_W-1:0] pwm_l_v;
		logic [PWM_W-1:0] pwm_r_v;
		logic             sel_v;
		logic             aud_v;
		logic             man_v;
		logic             force_v;
		logic             led_v;
		logic             mute_v;
		logic [15:0]      ext_l_v;
		logic [15:0]      ext_r_v;
		logic             byp_a;
		logic             byp_b;
		logic             due;
		int               x_l;
		int               x_r;
		int               a_l;
		int               a_r;
		int               el;
		int               er;
		@(posedge clk_sys);
		drive_cyc++;
		draw(8, r);
		ce_v = allow_ce && ((r % 32'd3) == 32'd0); // About one cycle in three
		draw(DAC_W, r);
		dac_l_v = r[DAC_W-1:0];
		draw(DAC_W, r);
		dac_r_v = r[DAC_W-1:0];
		draw(PWM_W, r);
		pwm_l_v = r[PWM_W-1:0];
		draw(PWM_W, r);
		pwm_r_v = r[PWM_W-1:0];
		draw(6, r);
		{sel_v, aud_v, man_v, force_v, led_v, mute_v} = r[5:0];
		draw(16, r);
		ext_l_v = r[15:0];
		draw(16, r);
		ext_r_v = r[15:0];

		case (phase)
			0: {sel_v, aud_v, man_v, force_v, mute_v} = 5'b01101; // DAC with both filters off
			1: {aud_v, man_v, force_v, mute_v} = 4'b1101;
			2: {man_v, mute_v} = 2'b11; // Manual filter enable
			3: {man_v, mute_v} = 2'b01; // LED follows power LED
			4: {sel_v, aud_v, man_v, force_v} = 4'b0110;
			default: ;
		endcase

		sample_ce  <= ce_v;
		dac_l      <= dac_l_v;
		dac_r      <= dac_r_v;
		pwm_l      <= pwm_l_v;
		pwm_r      <= pwm_r_v;
		pwm_sel    <= sel_v;
		aud_1200   <= aud_v;
		flt_manual <= man_v;
		flt_force  <= force_v;
		pwr_led    <= led_v;
		ext_l      <= ext_l_v;
		ext_r      <= ext_r_v;
		ext_mute   <= mute_v;

		if (ce_v) begin
			x_l   = sel_v ? to_s16({pwm_l_v, 7'd0}) : to_s16({dac_l_v, 1'b0});
			x_r   = sel_v ? to_s16({pwm_r_v, 7'd0}) : to_s16({dac_r_v, 1'b0});
			byp_a = aud_v;
			byp_b = ~(man_v ? force_v : led_v);
			// Both filters keep running while bypassed
			st_a_l = lp_step(x_l, st_a_l, LPF_A_SHIFT);
			st_a_r = lp_step(x_r, st_a_r, LPF_A_SHIFT);
			a_l    = byp_a ? x_l : st_a_l;
			a_r    = byp_a ? x_r : st_a_r;
			st_b_l = lp_step(a_l, st_b_l, LPF_B_SHIFT);
			st_b_r = lp_step(a_r, st_b_r, LPF_B_SHIFT);
			pend_l.push_back(byp_b ? a_l : st_b_l);
			pend_r.push_back(byp_b ? a_r : st_b_r);
			pend_due.push_back(drive_cyc + 3); // Mixer input strobe three cycles on
		end

		// Mixer takes the synth sample driven in this cycle
		if (pend_due.size() > 0 && pend_due[0] == drive_cyc) begin
			void'(pend_due.pop_front());
			mix_sample(pend_l.pop_front(), mute_v ? 0 : to_s16(ext_l_v), el);
			mix_sample(pend_r.pop_front(), mute_v ? 0 : to_s16(ext_r_v), er);
			exp_l.push_back(el);
			exp_r.push_back(er);
			exp_due.push_back(drive_cyc + 1);
		end
		ce_out = ce_v;

		@(negedge clk_sys);
		if (idle_check) begin
			check_value("audio_strobe", 16'd0, {15'd0, audio_strobe});
			check_value("audio_l", 16'd0, audio_l);
			check_value("audio_r", 16'd0, audio_r);
		end else if (audio_strobe && exp_l.size() == 0) begin
			errors++;
			$display("Error: audio_strobe went high with no sample expected at %0t", $time);
		end else begin
			due = exp_due.size() > 0 && exp_due[0] == drive_cyc;
			check_value("audio_strobe", {15'd0, due}, {15'd0, audio_strobe});
			if (due) begin
				void'(exp_due.pop_front());
				el = exp_l.pop_front();
				er = exp_r.pop_front();
				if (audio_strobe) begin
					check_value("audio_l", el[15:0], audio_l);
					check_value("audio_r", er[15:0], audio_r);
				end
			end
		end
	endtask

	initial begin
		lfsr       = 32'h3522;
		errors     = 0;
		checks     = 0;
		drive_cyc  = 0;
		clamp_pos  = 0;
		clamp_neg  = 0;
		idle_check = 1'b0;
		st_a_l     = 0;
		st_a_r     = 0;
		st_b_l     = 0;
		st_b_r     = 0;
		reset      = 1'b1;
		sample_ce  = 1'b0;
		dac_l      = '0;
		dac_r      = '0;
		pwm_l      = '0;
		pwm_r      = '0;
		pwm_sel    = 1'b0;
		aud_1200   = 1'b0;
		flt_manual = 1'b0;
		flt_force  = 1'b0;
		pwr_led    = 1'b0;
		ext_l      = '0;
		ext_r      = '0;
		ext_mute   = 1'b0;

		repeat (16) @(posedge clk_sys);
		reset <= 1'b0;

		idle_check = 1'b1; // Quiet outputs until the first sample
		repeat (IDLE_CYCLES) drive_cycle(0, 1'b0, took);
		idle_check = 1'b0;

		for (int phase = 0; phase < PHASES; phase++) begin
			sent = 0;
			while (sent < SAMPLES_PER_PHASE) begin
				drive_cycle(phase, 1'b1, took);
				if (took)
					sent++;
			end
		end
		repeat (DRAIN_CYCLES) drive_cycle(PHASES - 1, 1'b0, took);

		if (exp_l.size() != 0 || pend_due.size() != 0) begin
			errors++;
			$display("Error: %0d samples never came out of the pipeline",
				exp_l.size() + pend_due.size());
		end
		if (clamp_pos == 0 || clamp_neg == 0) begin
			errors++;
			$display("Error: mixing did not reach both clamp limits (positive %0d, negative %0d)",
				clamp_pos, clamp_neg);
		end

		$display("Checks: %0d, clamps: %0d/%0d, errors: %0d", checks, clamp_pos, clamp_neg,
			errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST FAIL");
			$finish;
		end
	end

endmodule

// File: filelist.f
rtl/audio_pkg.sv
rtl/paula_sample_format.sv
rtl/audio_lowpass.sv
rtl/audio_mixer.sv
rtl/paula_audio_top.sv
sim/tb_paula_audio.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the Paula audio testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
	-f filelist.f \
	--top-module tb_paula_audio \
	-o tb_paula_audio

output=$(./obj_dir/tb_paula_audio)
echo "$output"

if echo "$output" | grep -qx "TEST PASS"; then
	exit 0
else
	exit 1
fi
